// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_besm_mmu
FILELIST := besm_mmu.f
BUILD    := obj_dir
PASS_MSG := RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// ==== besm_mmu.f ====
src/besm_pkg.sv
src/page_ram.sv
src/cmd_decode.sv
src/page_translate.sv
src/page_flags.sv
src/result_out.sv
src/besm_mmu.sv
testbench/besm_mmu_props.sv
testbench/tb_besm_mmu.sv

// ==== src/besm_mmu.sv ====
// ----------------------------------------
// Paging unit top level
// Decoder, translation, flags, result
// ----------------------------------------

`timescale 1ns/1ns

module besm_mmu (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_cmd_valid,              // Command strobe
    input  besm_pkg::cmd_op_t i_cmd_op,
    input  besm_pkg::addr_t   i_addr,
    input  besm_pkg::addr_t   i_wdata,
    input  besm_pkg::arb_op_t i_arb_op,
    output logic              o_valid,                  // Two edges after command
    output besm_pkg::result_t o_result,
    output logic              o_busy                    // Reprio fill running
);
    import besm_pkg::*;

    logic        map_wr, xlate, paging_wr;
    logic        flags_rd, flags_wr, reprio_rd, fill;
    logic        mark_dirty;
    addr_t       cmd_addr, cmd_wdata;                   // Registered payload
    addr_t       phys;
    page_t       page_index;
    page_flags_t flags;
    logic        reprio;

    cmd_decode cmd_decode_i (
        .clk          (clk),          .reset       (reset),
        .i_cmd_valid  (i_cmd_valid),  .i_cmd_op    (i_cmd_op),
        .i_addr       (i_addr),       .i_wdata     (i_wdata),
        .i_arb_op     (i_arb_op),
        .o_map_wr     (map_wr),       .o_xlate     (xlate),
        .o_paging_wr  (paging_wr),    .o_flags_rd  (flags_rd),
        .o_flags_wr   (flags_wr),     .o_reprio_rd (reprio_rd),
        .o_fill       (fill),         .o_mark_dirty (mark_dirty),
        .o_addr       (cmd_addr),     .o_wdata     (cmd_wdata)
    );

    page_translate page_translate_i (
        .clk         (clk),        .reset        (reset),
        .i_map_wr    (map_wr),     .i_xlate      (xlate),
        .i_paging_wr (paging_wr),  .i_addr       (cmd_addr),
        .i_wdata     (cmd_wdata),  .o_phys       (phys),
        .o_page_index (page_index)
    );

    page_flags page_flags_i (
        .clk          (clk),         .reset        (reset),
        .i_xlate      (xlate),       .i_mark_dirty (mark_dirty),
        .i_flags_wr   (flags_wr),    .i_fill       (fill),
        .i_wdata      (cmd_wdata),   .i_phys       (phys),
        .i_page_index (page_index),  .o_flags      (flags),
        .o_reprio     (reprio),      .o_busy       (o_busy)
    );

    result_out result_out_i (
        .clk         (clk),        .reset      (reset),
        .i_xlate     (xlate),      .i_flags_rd (flags_rd),
        .i_reprio_rd (reprio_rd),  .i_phys     (phys),
        .i_flags     (flags),      .i_reprio   (reprio),
        .o_valid     (o_valid),    .o_result   (o_result)
    );

endmodule

// ==== src/besm_pkg.sv ====
// ----------------------------------------
// Paging unit shared definitions
// Widths, command and bus-op codes
// Payload types for map, flags and results
// ----------------------------------------

package besm_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int PAGE_BITS   = 10;                    // Page number, one word
    localparam int OFFSET_BITS = 10;                    // Offset inside a page
    localparam int ADDR_BITS   = 20;                    // Virtual or physical address
    localparam int NUM_PAGES   = 1024;                  // Pages in the map

    typedef logic [PAGE_BITS-1:0] page_t;               // Page number
    typedef logic [ADDR_BITS-1:0] addr_t;               // Page joined to offset

    // ----------------------------------------
    // Command codes
    // ----------------------------------------
    typedef enum logic [2:0] {
        CMD_NOP       = 3'd0,                           // Idle slot
        CMD_MAP_WR    = 3'd1,                           // Write page map entry
        CMD_XLATE     = 3'd2,                           // Translate, mark used/dirty
        CMD_PAGING    = 3'd3,                           // Paging-disable switch
        CMD_FLAGS_RD  = 3'd4,                           // Read used/dirty of indexed page
        CMD_FLAGS_WR  = 3'd5,                           // Write used/dirty of indexed page
        CMD_REPRIO_RD = 3'd6,                           // Read reprio bit of indexed page
        CMD_FILL      = 3'd7                            // Start reprio fill
    } cmd_op_t;

    // Bus-operation code, as seen by the arbiter
    typedef logic [3:0] arb_op_t;

    // Write-class bus ops, one bit per code
    // 2 icache wr, 4 dcache wr, 10 result wr, 11 rmw, 12 block wr
    localparam logic [15:0] ARB_WRITE_OPS = 16'h1C14;

    // ----------------------------------------
    // Payloads
    // ----------------------------------------
    typedef struct packed {
        logic dirty;                                    // Page was modified
        logic used;                                     // Page was referenced
    } page_flags_t;

    typedef logic [ADDR_BITS-1:0] result_t;             // Read result word

endpackage

// ==== src/cmd_decode.sv ====
// ----------------------------------------
// Command decoder for the paging unit
// Registers the command port
// One strobe per action, plus dirty level
// ----------------------------------------

`timescale 1ns/1ns

module cmd_decode (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_cmd_valid,              // Command strobe
    input  besm_pkg::cmd_op_t i_cmd_op,                 // Command code
    input  besm_pkg::addr_t   i_addr,                   // Virtual address
    input  besm_pkg::addr_t   i_wdata,                  // Write value
    input  besm_pkg::arb_op_t i_arb_op,                 // Bus op for dirty marking
    output logic              o_map_wr,
    output logic              o_xlate,
    output logic              o_paging_wr,
    output logic              o_flags_rd,
    output logic              o_flags_wr,
    output logic              o_reprio_rd,
    output logic              o_fill,
    output logic              o_mark_dirty,             // Bus op is write-class
    output besm_pkg::addr_t   o_addr,                   // Registered address
    output besm_pkg::addr_t   o_wdata                   // Registered write value
);
    import besm_pkg::*;

    // ----------------------------------------
    // Action strobes
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_map_wr    <= 1'b0;
            o_xlate     <= 1'b0;
            o_paging_wr <= 1'b0;
            o_flags_rd  <= 1'b0;
            o_flags_wr  <= 1'b0;
            o_reprio_rd <= 1'b0;
            o_fill      <= 1'b0;
        end else begin
            o_map_wr    <= i_cmd_valid && (i_cmd_op == CMD_MAP_WR);
            o_xlate     <= i_cmd_valid && (i_cmd_op == CMD_XLATE);
            o_paging_wr <= i_cmd_valid && (i_cmd_op == CMD_PAGING);
            o_flags_rd  <= i_cmd_valid && (i_cmd_op == CMD_FLAGS_RD);
            o_flags_wr  <= i_cmd_valid && (i_cmd_op == CMD_FLAGS_WR);
            o_reprio_rd <= i_cmd_valid && (i_cmd_op == CMD_REPRIO_RD);
            o_fill      <= i_cmd_valid && (i_cmd_op == CMD_FILL);
        end
    end

    // ----------------------------------------
    // Payload, qualified by the strobes
    // ----------------------------------------
    always_ff @(posedge clk) begin
        o_addr       <= i_addr;
        o_wdata      <= i_wdata;
        o_mark_dirty <= ARB_WRITE_OPS[i_arb_op];        // Only place bus op is looked at
    end

endmodule

// ==== src/page_flags.sv ====
// ----------------------------------------
// Per-page used/dirty memory
// Reprio bit memory with sequential fill
// ----------------------------------------

`timescale 1ns/1ns

module page_flags (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_xlate,              // Mark translated page
    input  logic                  i_mark_dirty,         // Translate is write-class
    input  logic                  i_flags_wr,           // Write indexed page flags
    input  logic                  i_fill,               // Start reprio fill
    input  besm_pkg::addr_t       i_wdata,              // Flags or fill value
    input  besm_pkg::addr_t       i_phys,               // Translated address
    input  besm_pkg::page_t       i_page_index,         // Indexed page
    output besm_pkg::page_flags_t o_flags,              // Indexed page flags
    output logic                  o_reprio,             // Indexed page reprio bit
    output logic                  o_busy                // Fill running
);
    import besm_pkg::*;

    page_t       phys_page;
    page_t       flag_addr;                             // Shared read/write page
    page_flags_t flag_rdata;
    page_flags_t flag_wdata;
    page_t       fill_cnt;                              // Next page to fill
    logic        fill_val;                              // Bit written by the fill
    logic        fill_busy;

    assign phys_page = i_phys[ADDR_BITS-1:OFFSET_BITS];

    // ----------------------------------------
    // Used/dirty, read-modify-write on xlate
    // ----------------------------------------
    assign flag_addr = i_xlate ? phys_page : i_page_index;

    always_comb begin
        if (i_xlate) begin
            flag_wdata.used  = 1'b1;                    // Referenced
            flag_wdata.dirty = flag_rdata.dirty | i_mark_dirty;   // Sticky
        end else begin
            flag_wdata.used  = i_wdata[1];              // Same layout as read
            flag_wdata.dirty = i_wdata[2];
        end
    end

    page_ram #(.entry_t(page_flags_t)) flags_ram_i (
        .clk     (clk),
        .i_we    (i_xlate | i_flags_wr),
        .i_waddr (flag_addr),
        .i_wdata (flag_wdata),
        .i_raddr (flag_addr),
        .o_rdata (flag_rdata)
    );

    assign o_flags = flag_rdata;

    // ----------------------------------------
    // Reprio fill, one page per cycle
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_busy <= 1'b0;
        end else if (fill_busy) begin
            if (fill_cnt == page_t'(NUM_PAGES - 1))
                fill_busy <= 1'b0;                      // Last page written
        end else if (i_fill) begin
            fill_busy <= 1'b1;                          // New fill ignored while busy
        end
    end

    always_ff @(posedge clk) begin
        if (fill_busy) begin
            fill_cnt <= fill_cnt + 1'b1;
        end else if (i_fill) begin
            fill_cnt <= i_page_index;                   // Start at indexed page
            fill_val <= i_wdata[0];
        end
    end

    page_ram #(.entry_t(logic)) reprio_ram_i (
        .clk     (clk),
        .i_we    (fill_busy),
        .i_waddr (fill_cnt),
        .i_wdata (fill_val),
        .i_raddr (i_page_index),
        .o_rdata (o_reprio)
    );

    assign o_busy = fill_busy;

endmodule

// ==== src/page_ram.sv ====
// ----------------------------------------
// Per-page memory, one entry per page
// Sync write, async read, any payload type
// ----------------------------------------

`timescale 1ns/1ns

module page_ram #(
    parameter type entry_t = logic                      // Stored payload
) (
    input  logic            clk,
    input  logic            i_we,                       // Write enable
    input  besm_pkg::page_t i_waddr,                    // Write page
    input  entry_t          i_wdata,                    // Write payload
    input  besm_pkg::page_t i_raddr,                    // Read page
    output entry_t          o_rdata                     // Read payload, same cycle
);
    import besm_pkg::*;

    entry_t mem [NUM_PAGES];                            // No reset, contents undefined

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata = mem[i_raddr];                      // Combinational lookup

endmodule

// ==== src/page_translate.sv ====
// ----------------------------------------
// Page map and address translation
// Paging-disable switch, page index register
// ----------------------------------------

`timescale 1ns/1ns

module page_translate (
    input  logic            clk,
    input  logic            reset,
    input  logic            i_map_wr,                   // Write map entry
    input  logic            i_xlate,                    // Translate, load page index
    input  logic            i_paging_wr,                // Set paging switch
    input  besm_pkg::addr_t i_addr,                     // Virtual address
    input  besm_pkg::addr_t i_wdata,                    // Map value or switch value
    output besm_pkg::addr_t o_phys,                     // Physical address
    output besm_pkg::page_t o_page_index                // Current physical page
);
    import besm_pkg::*;

    page_t virt_page;                                   // Page field of address
    page_t map_page;                                    // Map lookup result
    page_t phys_page;                                   // After paging switch
    logic  no_paging;                                   // Paging disabled
    page_t page_index;                                  // Page index register

    assign virt_page = i_addr[ADDR_BITS-1:OFFSET_BITS];

    // Map entry takes the page field of the write value
    page_ram #(.entry_t(page_t)) page_map_i (
        .clk     (clk),
        .i_we    (i_map_wr),
        .i_waddr (virt_page),
        .i_wdata (i_wdata[ADDR_BITS-1:OFFSET_BITS]),
        .i_raddr (virt_page),
        .o_rdata (map_page)
    );

    assign phys_page = no_paging ? virt_page : map_page;   // Identity when off
    assign o_phys    = {phys_page, i_addr[OFFSET_BITS-1:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            no_paging  <= 1'b0;                         // Paging on after reset
            page_index <= '0;
        end else begin
            if (i_paging_wr)
                no_paging <= i_wdata[0];                // 1 turns paging off
            if (i_xlate)
                page_index <= phys_page;                // Last translated page
        end
    end

    assign o_page_index = page_index;

endmodule

// ==== src/result_out.sv ====
// ----------------------------------------
// Read result select and output register
// One-cycle valid pulse per read command
// ----------------------------------------

`timescale 1ns/1ns

module result_out (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_xlate,              // Translate result
    input  logic                  i_flags_rd,           // Flags result
    input  logic                  i_reprio_rd,          // Reprio result
    input  besm_pkg::addr_t       i_phys,               // Physical address
    input  besm_pkg::page_flags_t i_flags,              // Indexed page flags
    input  logic                  i_reprio,             // Indexed page reprio
    output logic                  o_valid,              // Result strobe
    output besm_pkg::result_t     o_result              // Result word
);
    import besm_pkg::*;

    logic    rd_any;
    result_t result_d;

    assign rd_any = i_xlate | i_flags_rd | i_reprio_rd;

    always_comb begin
        result_d = '0;
        if (i_xlate)
            result_d = i_phys;
        else if (i_flags_rd)
            result_d = result_t'({i_flags.dirty, i_flags.used, 1'b0});   // Bit 0 spare
        else if (i_reprio_rd)
            result_d = result_t'(i_reprio);             // Zero-extended
    end

    always_ff @(posedge clk) begin
        if (reset)
            o_valid <= 1'b0;
        else
            o_valid <= rd_any;                          // Strobes are one-hot
    end

    always_ff @(posedge clk) begin
        if (rd_any)
            o_result <= result_d;                       // Held between reads
    end

endmodule

// ==== testbench/besm_mmu_props.sv ====
// ----------------------------------------
// Concurrent checks on the paging unit
// Reset state, result pulse, fill length
// ----------------------------------------

`timescale 1ns/1ns

module besm_mmu_props (
    input logic              clk,
    input logic              reset,
    input logic              i_cmd_valid,
    input besm_pkg::cmd_op_t i_cmd_op,
    input logic              o_valid,
    input logic              o_busy
);
    import besm_pkg::*;

    logic read_cmd;                                     // Command that returns a result
    int   busy_len;                                     // Edges o_busy has been high

    assign read_cmd = i_cmd_valid && (i_cmd_op inside {CMD_XLATE, CMD_FLAGS_RD, CMD_REPRIO_RD});

    always_ff @(posedge clk) begin
        if (reset)
            busy_len <= 0;
        else if (o_busy)
            busy_len <= busy_len + 1;
        else
            busy_len <= 0;                              // Restart on next fill
    end

    a_reset_idle: assert property (@(posedge clk) reset |=> !o_valid && !o_busy)
        else $error("o_valid or o_busy high after reset");

    a_valid_follows_read: assert property (@(posedge clk) disable iff (reset)
        read_cmd |-> ##2 o_valid)
        else $error("read command without o_valid two edges later");

    a_valid_has_read: assert property (@(posedge clk) disable iff (reset)
        o_valid |-> $past(read_cmd, 2))
        else $error("o_valid without a read command two edges earlier");

    a_fill_ends: assert property (@(posedge clk) disable iff (reset)
        o_busy |-> busy_len < NUM_PAGES)
        else $error("o_busy held longer than one pass over the pages");

endmodule

bind besm_mmu besm_mmu_props besm_mmu_props_i (
    .clk         (clk),
    .reset       (reset),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd_op    (i_cmd_op),
    .o_valid     (o_valid),
    .o_busy      (o_busy)
);

// ==== testbench/tb_besm_mmu.sv ====
// ----------------------------------------
// Testbench for the paging unit
// Clock, reset, stimulus, reference model
// In-order result compare, watchdog, report
// ----------------------------------------

`timescale 1ns/1ns

module tb_besm_mmu;
    import besm_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;                     // After rising edge
    localparam int N_RAND      = 16;                    // Map entries in test 1
    localparam int N_MIX       = 20;                    // Command groups in test 6
    localparam int CMD_CYCLES  = 4 + 3 * N_RAND + 40 + 5 * N_MIX + 6 * 4;
    localparam int WATCHDOG_NS = 2 * (CMD_CYCLES + 2 * (NUM_PAGES + 4)) * CLK_PERIOD;

    typedef struct {
        cmd_op_t op;                                    // Read command kind
        result_t val;                                   // Expected result word
        int      due;                                   // Cycle o_valid is due
    } exp_t;

    logic        clk, reset, i_cmd_valid;
    cmd_op_t     i_cmd_op;
    addr_t       i_addr, i_wdata;
    arb_op_t     i_arb_op;
    logic        o_valid, o_busy;
    result_t     o_result;

    // ----------------------------------------
    // Reference model state
    // ----------------------------------------
    page_t       m_map [NUM_PAGES];
    page_flags_t m_flags [NUM_PAGES];
    logic        m_reprio [NUM_PAGES];
    logic        m_no_paging  = 1'b0;                   // Paging on after reset
    page_t       m_index      = '0;
    int          m_fill_first = 0;                      // First edge busy is seen high
    int          m_busy_until = -1;                     // Last edge busy is seen high

    exp_t        exp_q [$];                             // Pending reads, in order
    exp_t        cur_exp;
    logic [31:0] rng = 32'd93823;
    int          cycle = 0;
    int          checks = 0, errors = 0, tests = 0;
    int          t_checks, t_errors;                    // Counts at test start
    string       cur_test;
    page_t       pages [N_RAND];
    page_t       start_page;
    addr_t       mix_addr;

    besm_mmu besm_mmu_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);                        // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic addr_t rand_addr();
        return addr_t'(next_random());
    endfunction

    function automatic addr_t page_addr(input page_t p);
        return {p, OFFSET_BITS'(next_random())};        // Random offset
    endfunction

    // icache wr, dcache wr, result wr, rmw, block wr
    function automatic logic is_write_class(input arb_op_t op);
        return op inside {4'd2, 4'd4, 4'd10, 4'd11, 4'd12};
    endfunction

    // Applies one command to the model, returns its read result
    function automatic result_t model_cmd(input cmd_op_t op, input addr_t addr,
                                          input addr_t wdata, input arb_op_t arb);
        page_t   vpage;
        page_t   ppage;
        result_t res;
        vpage = addr[ADDR_BITS-1:OFFSET_BITS];
        ppage = m_no_paging ? vpage : m_map[vpage];
        res   = '0;
        case (op)
            CMD_MAP_WR: m_map[vpage] = wdata[ADDR_BITS-1:OFFSET_BITS];
            CMD_PAGING: m_no_paging = wdata[0];
            CMD_XLATE: begin
                m_index = ppage;
                m_flags[ppage].used = 1'b1;
                if (is_write_class(arb))
                    m_flags[ppage].dirty = 1'b1;
                res = {ppage, addr[OFFSET_BITS-1:0]};
            end
            CMD_FLAGS_WR: begin
                m_flags[m_index].used  = wdata[1];
                m_flags[m_index].dirty = wdata[2];
            end
            CMD_FLAGS_RD: begin
                res[2] = m_flags[m_index].dirty;
                res[1] = m_flags[m_index].used;
            end
            CMD_REPRIO_RD: res[0] = m_reprio[m_index];
            CMD_FILL: begin
                if (!(cycle + 2 >= m_fill_first && cycle + 2 <= m_busy_until)) begin
                    for (int p = int'(m_index); p < NUM_PAGES; p++)
                        m_reprio[p] = wdata[0];
                    m_fill_first = cycle + 3;            // Busy seen after strobe edge
                    m_busy_until = cycle + NUM_PAGES + 2 - int'(m_index);
                end
            end
            default: ;
        endcase
        return res;
    endfunction

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_addr(input addr_t exp, input addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_flags(input page_flags_t exp, input page_flags_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected flags %b, actual %b", cur_test, exp, act);
        end
    endtask

    task automatic check_bit(input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected reprio %b, actual %b", cur_test, exp, act);
        end
    endtask

    // Each read must pulse o_valid exactly on its due cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
                cur_exp = exp_q.pop_front();
                if (o_valid !== 1'b1) begin
                    errors++;
                    $display("%s: no o_valid pulse for a read at cycle %0d", cur_test, cycle);
                end else if (cur_exp.op == CMD_XLATE)
                    check_addr(cur_exp.val, o_result);
                else if (cur_exp.op == CMD_FLAGS_RD) begin
                    check_flags(page_flags_t'(cur_exp.val[2:1]), page_flags_t'(o_result[2:1]));
                    check_addr('0, o_result & ~result_t'(6));   // Other bits zero
                end else begin
                    check_bit(cur_exp.val[0], o_result[0]);
                    check_addr('0, o_result & ~result_t'(1));   // Other bits zero
                end
            end else if (o_valid) begin
                errors++;
                $display("%s: o_valid pulse with no read due at cycle %0d", cur_test, cycle);
            end
        end
    end

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------
    task automatic issue(input cmd_op_t op, input addr_t addr, input addr_t wdata,
                         input arb_op_t arb);
        exp_t e;
        @(posedge clk);
        #(DRIVE_DELAY);
        i_cmd_valid = 1'b1;
        i_cmd_op    = op;
        i_addr      = addr;
        i_wdata     = wdata;
        i_arb_op    = arb;
        e.op  = op;
        e.val = model_cmd(op, addr, wdata, arb);
        e.due = cycle + 2;                              // Two edges later
        if (op inside {CMD_XLATE, CMD_FLAGS_RD, CMD_REPRIO_RD})
            exp_q.push_back(e);
    endtask

    task automatic idle();
        @(posedge clk);
        #(DRIVE_DELAY);
        i_cmd_valid = 1'b0;
        i_cmd_op    = CMD_NOP;
    endtask

    task automatic wait_fill_done();
        idle();
        while (o_busy || cycle < m_fill_first) begin
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        if (cycle != m_busy_until) begin
            errors++;
            $display("** Error %s: o_busy fall cycle expected %0d, actual %0d",
                     cur_test, m_busy_until, cycle);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        t_checks = checks;
        t_errors = errors;
    endtask

    task automatic end_test();
        idle();
        while (exp_q.size() > 0)
            @(posedge clk);                             // Drain the pipeline
        @(negedge clk);
        tests++;
        $display("%s: %0d checks, %0d errors", cur_test, checks - t_checks, errors - t_errors);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        reset       = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd_op    = CMD_NOP;
        i_addr      = '0;
        i_wdata     = '0;
        i_arb_op    = '0;
        repeat (4) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;

        start_test("xlate_paging_on");
        for (int i = 0; i < N_RAND; i++) begin
            pages[i] = page_t'(next_random());
            issue(CMD_MAP_WR, page_addr(pages[i]), rand_addr(), '0);
        end
        for (int i = 0; i < N_RAND; i++)
            issue(CMD_XLATE, page_addr(pages[i]), '0, arb_op_t'(next_random()));
        end_test();

        start_test("paging_off");
        issue(CMD_PAGING, '0, addr_t'(1), '0);          // Identity translation
        repeat (4) issue(CMD_XLATE, rand_addr(), '0, '0);
        end_test();

        start_test("used_dirty");
        mix_addr = rand_addr();
        issue(CMD_XLATE, mix_addr, '0, 4'd0);
        issue(CMD_FLAGS_WR, '0, '0, '0);                // Clear used and dirty
        issue(CMD_XLATE, mix_addr, '0, 4'd1);           // Read class
        issue(CMD_FLAGS_RD, '0, '0, '0);
        issue(CMD_XLATE, mix_addr, '0, 4'd11);          // Read-modify-write
        issue(CMD_FLAGS_RD, '0, '0, '0);
        end_test();

        start_test("flags_rw");
        repeat (4) begin
            issue(CMD_FLAGS_WR, '0, rand_addr() & addr_t'(6), '0);
            issue(CMD_FLAGS_RD, '0, '0, '0);
        end
        end_test();

        start_test("reprio_fill");
        issue(CMD_XLATE, page_addr('0), '0, '0);
        issue(CMD_FILL, '0, addr_t'(0), '0);            // Whole memory to 0
        wait_fill_done();
        start_page = page_t'(1 + next_random() % (NUM_PAGES - 1));
        issue(CMD_XLATE, page_addr(start_page), '0, '0);
        issue(CMD_FILL, '0, addr_t'(1), '0);
        issue(CMD_FILL, '0, addr_t'(0), '0);            // Arrives while busy
        wait_fill_done();
        issue(CMD_XLATE, page_addr(start_page - 1'b1), '0, '0);
        issue(CMD_REPRIO_RD, '0, '0, '0);
        issue(CMD_XLATE, page_addr(start_page), '0, '0);
        issue(CMD_REPRIO_RD, '0, '0, '0);
        issue(CMD_XLATE, page_addr(page_t'(NUM_PAGES - 1)), '0, '0);
        issue(CMD_REPRIO_RD, '0, '0, '0);
        end_test();

        start_test("back_to_back");
        issue(CMD_PAGING, '0, '0, '0);                  // Paging back on
        repeat (N_MIX) begin
            mix_addr = rand_addr();
            issue(CMD_MAP_WR, mix_addr, rand_addr(), '0);
            issue(CMD_XLATE, mix_addr, '0, arb_op_t'(next_random()));
            issue(CMD_FLAGS_WR, '0, rand_addr() & addr_t'(6), '0);
            issue(CMD_FLAGS_RD, '0, '0, '0);
            issue(CMD_REPRIO_RD, '0, '0, '0);
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
